//--- design/raster_macros.svh
// rasterizer width and count macros
//   coordinate and edge-value width
//   number of edge functions
//   sign bit index of an edge value

`ifndef RASTER_MACROS_SVH
`define RASTER_MACROS_SVH

// one screen word, shared by coordinates and edge values
`define RASTER_COORD_W 16

// one edge function per triangle side
`define RASTER_NUM_EDGES 3

// msb of an edge value
// set means the point lies outside that edge
`define RASTER_SIGN_BIT 15

`endif

//--- design/raster_pkg.sv
// rasterizer types
//   coord_t      screen x or y coordinate
//   edge_val_t   edge coefficient or edge value
//   scan_state_t setup and scan FSM states

`include "raster_macros.svh"

package raster_pkg;

	// screen coordinate, unsigned pixel index
	typedef logic [`RASTER_COORD_W-1:0] coord_t;

	// edge coefficients and values wrap mod 2^16
	// sign bit is read as two's complement
	typedef logic [`RASTER_COORD_W-1:0] edge_val_t;

	// scan FSM
	// IDLE until the first loop setup, READY holds the start point,
	// SCAN while walking the box, FINISHED once the last point left
	typedef enum logic [1:0] {
		IDLE,
		READY,
		SCAN,
		FINISHED
	} scan_state_t;

endpackage

//--- design/raster_ifs.sv
// rasterizer interfaces
//   tri_if   latched vertices of the current triangle
//   scan_if  one scan point per cycle from the box walker

`timescale 1ns/1ps

interface tri_if import raster_pkg::*; ();

	// vertices in counterclockwise order
	coord_t v0_x;
	coord_t v0_y;
	coord_t v1_x;
	coord_t v1_y;
	coord_t v2_x;
	coord_t v2_y;

	// setup side owns the vertex latch
	modport source (output v0_x, v0_y, v1_x, v1_y, v2_x, v2_y);

	// edge evaluators only read
	modport sink (input v0_x, v0_y, v1_x, v1_y, v2_x, v2_y);

endinterface

interface scan_if import raster_pkg::*; ();

	// high for exactly one cycle per point
	logic point_valid;
	// final point of the bounding box
	logic point_last;
	coord_t point_x;
	coord_t point_y;

	modport source (output point_valid, point_last, point_x, point_y);

	modport sink (input point_valid, point_last, point_x, point_y);

endinterface

//--- design/raster_setup.sv
// triangle setup and scan point generator
//   vertex latch on start_triangle
//   bounding box on get_bounds, ties included
//   row-order box walk with one registered point per enabled cycle

`timescale 1ns/1ps

module raster_setup import raster_pkg::*; (
	input logic clock,
	input logic rst,
	input logic start_triangle,
	input logic get_bounds,
	input logic loop_setup,
	input logic rasterize,
	input coord_t v0_x,
	input coord_t v0_y,
	input coord_t v1_x,
	input coord_t v1_y,
	input coord_t v2_x,
	input coord_t v2_y,
	tri_if.source tri_vtx,
	scan_if.source scan
);

	scan_state_t state;
	coord_t min_x;
	coord_t min_y;
	coord_t max_x;
	coord_t max_y;
	coord_t iter_x;
	coord_t iter_y;
	logic row_end;
	logic box_end;
	logic issue;

	// non-strict compares, so equal coordinates still pick a real minimum
	function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
		coord_t m;
		m = (a <= b) ? a : b;
		return (m <= c) ? m : c;
	endfunction

	function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
		coord_t m;
		m = (a >= b) ? a : b;
		return (m >= c) ? m : c;
	endfunction

	// vertex latch, held for the whole triangle
	always_ff @(posedge clock) begin
		if (start_triangle) begin
			tri_vtx.v0_x <= v0_x;
			tri_vtx.v0_y <= v0_y;
			tri_vtx.v1_x <= v1_x;
			tri_vtx.v1_y <= v1_y;
			tri_vtx.v2_x <= v2_x;
			tri_vtx.v2_y <= v2_y;
		end
	end

	// bounding box from the latched vertices
	always_ff @(posedge clock) begin
		if (get_bounds) begin
			min_x <= min3(tri_vtx.v0_x, tri_vtx.v1_x, tri_vtx.v2_x);
			min_y <= min3(tri_vtx.v0_y, tri_vtx.v1_y, tri_vtx.v2_y);
			max_x <= max3(tri_vtx.v0_x, tri_vtx.v1_x, tri_vtx.v2_x);
			max_y <= max3(tri_vtx.v0_y, tri_vtx.v1_y, tri_vtx.v2_y);
		end
	end

	// iterator sits at or below the max, so equality ends a row
	assign row_end = (iter_x == max_x);
	assign box_end = row_end && (iter_y == max_y);

	// no new point once the last one is on the bus
	assign issue = rasterize && ((state == READY) || (state == SCAN)) &&
		!(scan.point_valid && scan.point_last);

	// scan FSM and point strobes
	always_ff @(posedge clock) begin
		if (rst) begin
			state <= IDLE;
			scan.point_valid <= 1'b0;
			scan.point_last <= 1'b0;
		end else if (loop_setup) begin
			state <= READY;
			scan.point_valid <= 1'b0;
			scan.point_last <= 1'b0;
		end else begin
			scan.point_valid <= issue;
			scan.point_last <= issue && box_end;
			// finish after the last point has been seen downstream
			if (scan.point_valid && scan.point_last) begin
				state <= FINISHED;
			end else if (issue) begin
				state <= SCAN;
			end
		end
	end

	// point payload and iterator step
	always_ff @(posedge clock) begin
		if (loop_setup) begin
			iter_x <= min_x;
			iter_y <= min_y;
		end else if (issue) begin
			scan.point_x <= iter_x;
			scan.point_y <= iter_y;
			if (row_end) begin
				// wrap to the next row
				iter_x <= min_x;
				iter_y <= iter_y + 16'd1;
			end else begin
				iter_x <= iter_x + 16'd1;
			end
		end
	end

endmodule

//--- design/edge_evaluator.sv
// single edge function evaluator
//   coefficients a, b, c formed on form_edges
//   registered sign test per valid scan point

`timescale 1ns/1ps
`include "raster_macros.svh"

module edge_evaluator import raster_pkg::*; #(
	parameter int EDGE_INDEX = 0
) (
	input logic clock,
	input logic rst,
	input logic form_edges,
	tri_if.sink tri_vtx,
	scan_if.sink scan,
	output logic edge_ok
);

	// the two vertices opposite this edge index
	localparam int J_IDX = (EDGE_INDEX + 1) % `RASTER_NUM_EDGES;
	localparam int K_IDX = (EDGE_INDEX + 2) % `RASTER_NUM_EDGES;

	coord_t vx [`RASTER_NUM_EDGES];
	coord_t vy [`RASTER_NUM_EDGES];
	edge_val_t coef_a;
	edge_val_t coef_b;
	edge_val_t coef_c;
	edge_val_t edge_value;

	// index the vertices so the parameter picks j and k
	assign vx[0] = tri_vtx.v0_x;
	assign vy[0] = tri_vtx.v0_y;
	assign vx[1] = tri_vtx.v1_x;
	assign vy[1] = tri_vtx.v1_y;
	assign vx[2] = tri_vtx.v2_x;
	assign vy[2] = tri_vtx.v2_y;

	// all products truncate to one word
	always_ff @(posedge clock) begin
		if (form_edges) begin
			coef_a <= vy[J_IDX] - vy[K_IDX];
			coef_b <= vx[K_IDX] - vx[J_IDX];
			coef_c <= vy[K_IDX] * vx[J_IDX] - vx[K_IDX] * vy[J_IDX];
		end
	end

	// a*x + b*y + c, mod 2^16
	assign edge_value = coef_a * scan.point_x + coef_b * scan.point_y + coef_c;

	// clear sign bit means on or inside this edge
	always_ff @(posedge clock) begin
		if (rst) begin
			edge_ok <= 1'b0;
		end else if (scan.point_valid) begin
			edge_ok <= ~edge_value[`RASTER_SIGN_BIT];
		end
	end

endmodule

//--- design/pixel_emitter.sv
// pixel output stage
//   one-cycle delay of the scan point to meet the edge results
//   registered write strobe, pixel coordinates and done pulse

`timescale 1ns/1ps
`include "raster_macros.svh"

module pixel_emitter import raster_pkg::*; (
	input logic clock,
	input logic rst,
	scan_if.sink scan,
	input logic [`RASTER_NUM_EDGES-1:0] edge_ok,
	output logic write_pixel,
	output logic raster_done,
	output coord_t pixel_x,
	output coord_t pixel_y
);

	logic d_valid;
	logic d_last;
	coord_t d_x;
	coord_t d_y;
	logic covered;

	// point aligned with the evaluator registers
	always_ff @(posedge clock) begin
		if (rst) begin
			d_valid <= 1'b0;
			d_last <= 1'b0;
		end else begin
			d_valid <= scan.point_valid;
			d_last <= scan.point_valid && scan.point_last;
		end
		d_x <= scan.point_x;
		d_y <= scan.point_y;
	end

	// inside only if every edge agrees
	assign covered = d_valid && (&edge_ok);

	always_ff @(posedge clock) begin
		if (rst) begin
			write_pixel <= 1'b0;
			raster_done <= 1'b0;
		end else begin
			write_pixel <= covered;
			// done rides with the last point's result, inside or not
			raster_done <= d_valid && d_last;
		end
		// coordinates hold between inside points
		if (covered) begin
			pixel_x <= d_x;
			pixel_y <= d_y;
		end
	end

endmodule

//--- design/edge_rasterizer.sv
// edge function triangle rasterizer, top level
//   raster_setup    vertex latch, box and scan walker
//   edge_evaluator  one per edge, generate loop
//   pixel_emitter   coverage combine and pixel outputs

`timescale 1ns/1ps
`include "raster_macros.svh"

module edge_rasterizer import raster_pkg::*; (
	input logic clock,
	input logic rst,
	// control strobes, one per cycle in this order
	input logic start_triangle,
	input logic get_bounds,
	input logic form_edges,
	input logic loop_setup,
	// level, low holds the scan
	input logic rasterize,
	input coord_t v0_x,
	input coord_t v0_y,
	input coord_t v1_x,
	input coord_t v1_y,
	input coord_t v2_x,
	input coord_t v2_y,
	output logic write_pixel,
	output logic raster_done,
	output coord_t pixel_x,
	output coord_t pixel_y
);

	tri_if tri_vtx ();
	scan_if scan ();

	// per-edge inside bits, one cycle behind the scan point
	logic [`RASTER_NUM_EDGES-1:0] edge_ok;

	raster_setup u_setup (
		.clock          (clock),
		.rst            (rst),
		.start_triangle (start_triangle),
		.get_bounds     (get_bounds),
		.loop_setup     (loop_setup),
		.rasterize      (rasterize),
		.v0_x           (v0_x),
		.v0_y           (v0_y),
		.v1_x           (v1_x),
		.v1_y           (v1_y),
		.v2_x           (v2_x),
		.v2_y           (v2_y),
		.tri_vtx        (tri_vtx.source),
		.scan           (scan.source)
	);

	// edge i is opposite vertex i
	for (genvar i = 0; i < `RASTER_NUM_EDGES; i++) begin : g_edge
		edge_evaluator #(
			.EDGE_INDEX (i)
		) u_edge (
			.clock      (clock),
			.rst        (rst),
			.form_edges (form_edges),
			.tri_vtx    (tri_vtx.sink),
			.scan       (scan.sink),
			.edge_ok    (edge_ok[i])
		);
	end

	pixel_emitter u_emitter (
		.clock       (clock),
		.rst         (rst),
		.scan        (scan.sink),
		.edge_ok     (edge_ok),
		.write_pixel (write_pixel),
		.raster_done (raster_done),
		.pixel_x     (pixel_x),
		.pixel_y     (pixel_y)
	);

endmodule

//--- testbench/rasterizer_assertions.sv
// bound checks for the rasterizer
//   done pulse lasts one cycle
//   output strobes low after a reset cycle
//   no scan point while idle or finished

`timescale 1ns/1ps

module rasterizer_assertions import raster_pkg::*; (
	input logic clock,
	input logic rst,
	input logic write_pixel,
	input logic raster_done,
	input logic point_valid,
	input scan_state_t state
);

	// done marks one result only
	done_one_cycle: assert property (@(posedge clock) disable iff (rst)
		raster_done |=> !raster_done)
		else $error("raster_done stayed high for two cycles");

	// sync reset clears the output strobes one edge later
	strobes_in_reset: assert property (@(posedge clock)
		rst |=> (!write_pixel && !raster_done))
		else $error("write_pixel or raster_done high during reset");

	// points only leave while a scan is armed or running
	point_in_scan: assert property (@(posedge clock) disable iff (rst)
		!(point_valid && ((state == FINISHED) || (state == IDLE))))
		else $error("scan point issued outside READY or SCAN");

endmodule

//--- testbench/rasterizer_tb.sv
// testbench for the edge function rasterizer
//   triangle table with per-row rasterize gap patterns
//   coverage model over the bounding box in row order
//   immediate checks on the pixel stream and the done pulse

`timescale 1ns/1ps

module rasterizer_tb import raster_pkg::*; ();

	localparam int MAX_TRI = 8;
	localparam int SCAN_TIMEOUT = 1000;
	localparam int QUIET_CYCLES = 20;
	localparam int DRAIN_CYCLES = 12;

	logic clock, rst;
	logic start_triangle, get_bounds, form_edges, loop_setup, rasterize;
	coord_t v0_x, v0_y, v1_x, v1_y, v2_x, v2_y;
	logic write_pixel, raster_done;
	coord_t pixel_x, pixel_y;

	// table rows hold the vertices, a gap mask and a reload flag
	// a set gap bit holds rasterize low for that cycle
	coord_t tab_x [MAX_TRI][3];
	coord_t tab_y [MAX_TRI][3];
	logic [15:0] tab_gap [MAX_TRI];
	logic tab_reload [MAX_TRI];
	int tab_count = 0;

	// expected inside points in row order
	coord_t exp_x [$];
	coord_t exp_y [$];
	// whether the far corner of the box is covered
	logic last_inside;

	edge_rasterizer UUT (.*);

	bind edge_rasterizer rasterizer_assertions checks (.clock(clock), .rst(rst),
		.write_pixel(write_pixel), .raster_done(raster_done),
		.point_valid(scan.point_valid), .state(u_setup.state));

	always #2 clock = ~clock;

	task automatic add_triangle(input coord_t x0, input coord_t y0, input coord_t x1,
		input coord_t y1, input coord_t x2, input coord_t y2, input logic [15:0] gap,
		input logic reload);
		tab_x[tab_count] = '{x0, x1, x2};
		tab_y[tab_count] = '{y0, y1, y2};
		tab_gap[tab_count] = gap;
		tab_reload[tab_count] = reload;
		tab_count++;
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("Fail %s got 0x%0h expected 0x%0h", name, got, expected);
		$display("Regression failed");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic abort_with(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "%s", reason);
	endtask

	// edge i uses vertices j = i+1 and k = i+2 and all terms wrap to one word
	function automatic logic edge_inside(input int idx, input int i, input coord_t px,
		input coord_t py);
		int j;
		int k;
		edge_val_t a;
		edge_val_t b;
		edge_val_t c;
		edge_val_t e;
		j = (i + 1) % 3;
		k = (i + 2) % 3;
		a = tab_y[idx][j] - tab_y[idx][k];
		b = tab_x[idx][k] - tab_x[idx][j];
		c = tab_y[idx][k] * tab_x[idx][j] - tab_x[idx][k] * tab_y[idx][j];
		e = a * px + b * py + c;
		return !e[$bits(edge_val_t)-1];
	endfunction

	// walk the true box, ties included, and keep points inside all three edges
	function automatic void build_coverage_list(input int idx);
		coord_t lo_x;
		coord_t hi_x;
		coord_t lo_y;
		coord_t hi_y;
		lo_x = tab_x[idx][0];
		hi_x = lo_x;
		lo_y = tab_y[idx][0];
		hi_y = lo_y;
		for (int v = 1; v < 3; v++) begin
			lo_x = (tab_x[idx][v] < lo_x) ? tab_x[idx][v] : lo_x;
			hi_x = (tab_x[idx][v] > hi_x) ? tab_x[idx][v] : hi_x;
			lo_y = (tab_y[idx][v] < lo_y) ? tab_y[idx][v] : lo_y;
			hi_y = (tab_y[idx][v] > hi_y) ? tab_y[idx][v] : hi_y;
		end
		exp_x.delete();
		exp_y.delete();
		for (int y = int'(lo_y); y <= int'(hi_y); y++) begin
			for (int x = int'(lo_x); x <= int'(hi_x); x++) begin
				if (edge_inside(idx, 0, 16'(x), 16'(y)) && edge_inside(idx, 1, 16'(x), 16'(y)) &&
					edge_inside(idx, 2, 16'(x), 16'(y))) begin
					exp_x.push_back(16'(x));
					exp_y.push_back(16'(y));
				end
			end
		end
		// the last box point decides whether done rides with a write
		last_inside = edge_inside(idx, 0, hi_x, hi_y) && edge_inside(idx, 1, hi_x, hi_y) &&
			edge_inside(idx, 2, hi_x, hi_y);
	endfunction

	// new vertices, then box and edge setup with one strobe per cycle
	task automatic load_triangle(input int idx);
		@(negedge clock);
		{v0_x, v1_x, v2_x} = {tab_x[idx][0], tab_x[idx][1], tab_x[idx][2]};
		{v0_y, v1_y, v2_y} = {tab_y[idx][0], tab_y[idx][1], tab_y[idx][2]};
		start_triangle = 1'b1;
		@(negedge clock);
		start_triangle = 1'b0;
		get_bounds = 1'b1;
		@(negedge clock);
		get_bounds = 1'b0;
		form_edges = 1'b1;
		@(negedge clock);
		form_edges = 1'b0;
	endtask

	task automatic restart_scan();
		@(negedge clock);
		loop_setup = 1'b1;
		@(negedge clock);
		loop_setup = 1'b0;
	endtask

	// sample at the falling edge, then set rasterize from the gap mask
	task automatic run_scan(input int idx);
		int cycle;
		int seen;
		bit done_seen;
		cycle = 0;
		seen = 0;
		done_seen = 1'b0;
		rasterize = !tab_gap[idx][0];
		while (!done_seen) begin
			@(negedge clock);
			cycle++;
			if (cycle > SCAN_TIMEOUT)
				abort_with("timeout waiting for raster_done");
			if (write_pixel) begin
				assert (seen < exp_x.size())
					else abort_with("write_pixel beyond the expected pixel list");
				assert (pixel_x == exp_x[seen])
					else report_mismatch("pixel_x", 32'(pixel_x), 32'(exp_x[seen]));
				assert (pixel_y == exp_y[seen])
					else report_mismatch("pixel_y", 32'(pixel_y), 32'(exp_y[seen]));
				seen++;
			end
			if (raster_done) begin
				assert (seen == exp_x.size())
					else report_mismatch("write_pixel count", seen, exp_x.size());
				assert (write_pixel == last_inside)
					else report_mismatch("write_pixel", 32'(write_pixel), 32'(last_inside));
				done_seen = 1'b1;
			end
			rasterize = !tab_gap[idx][cycle[3:0]];
		end
		// finished scan ignores rasterize until the next loop setup
		rasterize = 1'b1;
		repeat (DRAIN_CYCLES) begin
			@(negedge clock);
			assert (!write_pixel) else report_mismatch("write_pixel", 32'(write_pixel), 32'd0);
			assert (!raster_done) else report_mismatch("raster_done", 32'(raster_done), 32'd0);
		end
		rasterize = 1'b0;
	endtask

	initial begin
		clock = 1'b0;
		rst = 1'b1;
		{start_triangle, get_bounds, form_edges, loop_setup, rasterize} = '0;
		{v0_x, v0_y, v1_x, v1_y, v2_x, v2_y} = '0;
		// counterclockwise triangles, shared min and max, a vertex tie, gaps, rescan
		add_triangle(2, 2, 9, 3, 4, 8, 16'h0000, 1'b1);
		add_triangle(3, 3, 10, 3, 3, 9, 16'h0000, 1'b1);
		add_triangle(4, 4, 11, 4, 11, 9, 16'h0000, 1'b1);
		add_triangle(5, 5, 5, 5, 12, 10, 16'h0000, 1'b1);
		add_triangle(20, 6, 30, 12, 18, 16, 16'h9c31, 1'b1);
		add_triangle(20, 6, 30, 12, 18, 16, 16'h0421, 1'b0);
		repeat (4) @(negedge clock);
		rst = 1'b0;
		// outputs stay quiet while no strobe has been given
		repeat (QUIET_CYCLES) begin
			@(negedge clock);
			assert (!write_pixel) else report_mismatch("write_pixel", 32'(write_pixel), 32'd0);
			assert (!raster_done) else report_mismatch("raster_done", 32'(raster_done), 32'd0);
		end
		for (int t = 0; t < tab_count; t++) begin
			if (tab_reload[t])
				load_triangle(t);
			restart_scan();
			build_coverage_list(t);
			run_scan(t);
		end
		$display("Regression passed");
		$finish;
	end

endmodule

//--- all.f
+incdir+design
design/raster_pkg.sv
design/raster_ifs.sv
design/raster_setup.sv
design/edge_evaluator.sv
design/pixel_emitter.sv
design/edge_rasterizer.sv
testbench/rasterizer_assertions.sv
testbench/rasterizer_tb.sv

//--- Makefile
# Verilator build and run of the rasterizer regression
# the simulator exit status is the pass or fail result

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the regression"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module rasterizer_tb -f all.f -o rasterizer_sim
	./obj_dir/rasterizer_sim

clean:
	rm -rf obj_dir
